// File: rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// first fetch after reset
`define RV_RESET_PC 32'h0000_0000

`define RV_NUM_REGS 32

// major opcodes, bits 6:0 of the instruction
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111

`define RV_NOP 32'h0000_0013 // addi x0, x0, 0

`endif

// File: rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_kind_e;

    typedef struct packed {
        alu_op_e    alu_op;
        br_kind_e   br_kind;
        logic       src_a_pc;   // operand a is the pc
        logic       src_b_imm;  // operand b is the immediate
        logic       link;       // result is pc + 4
        logic       rd_we;
        logic [4:0] rd_sel;
    } ctrl_word_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
    } fd_payload_t;

    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] pc;
        logic [4:0]  rs1_sel;
        logic [4:0]  rs2_sel;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
    } de_payload_t;

endpackage

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic load_i,
    input  wire logic flush_i,
    input  wire logic valid_i,
    input  payload_t  data_i,
    output logic      valid_o,
    output payload_t  data_o
);

    // valid bit, flush wins over load
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only, stays put on flush
    always_ff @(posedge clk_i) begin
        if (load_i && !flush_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module fetch_unit
    import rv_core_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        imem_resp_i,
    input  wire logic [31:0] imem_rdata_i,
    input  wire logic        redirect_i,
    input  wire logic [31:0] redirect_pc_i,
    output logic             imem_req_o,
    output logic [31:0]      imem_addr_o,
    output logic             fd_load_o,
    output logic             fd_valid_o,
    output fd_payload_t      fd_data_o
);

    logic        req_q;
    logic [31:0] addr_q;     // address of the outstanding request
    logic [31:0] pc_q;       // next address to request
    logic        drop_q;     // outstanding request belongs to the old path
    logic        fd_live_q;  // fd entry needs clearing next cycle
    logic        resp_ok;

    // response we actually want to pass on
    assign resp_ok = imem_resp_i & ~drop_q & ~redirect_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q     <= 1'b0;
            addr_q    <= `RV_RESET_PC;
            pc_q      <= `RV_RESET_PC;
            drop_q    <= 1'b0;
            fd_live_q <= 1'b0;
        end else begin
            fd_live_q <= resp_ok;
            if (!req_q) begin
                // idle cycle, issue the next request
                req_q  <= 1'b1;
                addr_q <= redirect_i ? redirect_pc_i : pc_q;
                if (redirect_i) begin
                    pc_q <= redirect_pc_i;
                end
            end else if (imem_resp_i) begin
                req_q  <= 1'b0;
                drop_q <= 1'b0;
                if (redirect_i) begin
                    pc_q <= redirect_pc_i;
                end else if (resp_ok) begin
                    pc_q <= addr_q + 32'd4;
                end
            end else if (redirect_i) begin
                // address must stay stable, so remember to drop the answer
                drop_q <= 1'b1;
                pc_q   <= redirect_pc_i;
            end
        end
    end

    assign imem_req_o  = req_q;
    assign imem_addr_o = addr_q;

    assign fd_valid_o      = resp_ok;
    assign fd_load_o       = resp_ok | fd_live_q;  // second load retires the entry
    assign fd_data_o.instr = imem_rdata_i;
    assign fd_data_o.pc    = addr_q;

endmodule

`default_nettype wire

// File: decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module decode_unit
    import rv_core_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        fd_valid_i,
    input  fd_payload_t      fd_data_i,
    input  wire logic        wb_we_i,
    input  wire logic [4:0]  wb_sel_i,
    input  wire logic [31:0] wb_data_i,
    output logic             de_valid_o,
    output de_payload_t      de_data_o
);

    logic [31:0] regs [0:`RV_NUM_REGS-1];

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1_sel;
    logic [4:0]  rs2_sel;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    ctrl_word_t  ctrl;
    logic [31:0] imm;

    assign instr   = fd_data_i.instr;
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.br_kind   = BR_NONE;
        ctrl.rd_sel    = instr[11:7];
        imm            = imm_s;  // no store path, any other format picks its own
        case (opcode)
            `RV_OP_OP, `RV_OP_OP_IMM: begin
                ctrl.rd_we     = 1'b1;
                ctrl.src_b_imm = (opcode == `RV_OP_OP_IMM);
                imm            = imm_i;
                case (funct3)
                    3'b000: begin
                        // no subi, funct7 only counts for register ops
                        if (funct7[5] && opcode == `RV_OP_OP) begin
                            ctrl.alu_op = ALU_SUB;
                        end else begin
                            ctrl.alu_op = ALU_ADD;
                        end
                    end
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            `RV_OP_LUI: begin
                ctrl.rd_we     = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm            = imm_u;
            end
            `RV_OP_AUIPC: begin
                ctrl.rd_we     = 1'b1;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm            = imm_u;
            end
            `RV_OP_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000: ctrl.br_kind = BR_BEQ;
                    3'b001: ctrl.br_kind = BR_BNE;
                    3'b100: ctrl.br_kind = BR_BLT;
                    3'b101: ctrl.br_kind = BR_BGE;
                    3'b110: ctrl.br_kind = BR_BLTU;
                    3'b111: ctrl.br_kind = BR_BGEU;
                    default: ctrl.br_kind = BR_NONE;
                endcase
            end
            `RV_OP_JAL: begin
                ctrl.rd_we   = 1'b1;
                ctrl.link    = 1'b1;
                ctrl.br_kind = BR_JAL;
                imm          = imm_j;
            end
            `RV_OP_JALR: begin
                ctrl.rd_we   = 1'b1;
                ctrl.link    = 1'b1;
                ctrl.br_kind = BR_JALR;
                imm          = imm_i;
            end
            default: ctrl.rd_we = 1'b0;  // illegal, commits as a no-op
        endcase
        if (!ctrl.rd_we) begin
            ctrl.rd_sel = 5'd0;  // branch rd field is immediate bits
        end
    end

    // register file, x0 never written
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb_we_i && wb_sel_i != 5'd0) begin
            regs[wb_sel_i] <= wb_data_i;
        end
    end

    assign de_valid_o         = fd_valid_i;
    assign de_data_o.ctrl     = ctrl;
    assign de_data_o.pc       = fd_data_i.pc;
    assign de_data_o.rs1_sel  = rs1_sel;
    assign de_data_o.rs2_sel  = rs2_sel;
    assign de_data_o.imm      = imm;

    // reads with write-through from the result register
    assign de_data_o.rs1_data = (rs1_sel == 5'd0) ? 32'd0 :
                                (wb_we_i && wb_sel_i == rs1_sel) ? wb_data_i : regs[rs1_sel];
    assign de_data_o.rs2_data = (rs2_sel == 5'd0) ? 32'd0 :
                                (wb_we_i && wb_sel_i == rs2_sel) ? wb_data_i : regs[rs2_sel];

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit
    import rv_core_pkg::*;
(
    input  wire logic        de_valid_i,
    input  de_payload_t      de_data_i,
    input  wire logic        wb_we_i,
    input  wire logic [4:0]  wb_sel_i,
    input  wire logic [31:0] wb_data_i,
    output logic             exe_valid_o,
    output logic             exe_rd_we_o,
    output logic [4:0]       exe_rd_sel_o,
    output logic [31:0]      exe_result_o,
    output logic             redirect_o,
    output logic [31:0]      redirect_pc_o
);

    ctrl_word_t  ctrl;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic        taken;

    assign ctrl = de_data_i.ctrl;

    // forward from the result register, producer one ahead
    assign rs1_val = (wb_we_i && wb_sel_i != 5'd0 && wb_sel_i == de_data_i.rs1_sel) ?
                     wb_data_i : de_data_i.rs1_data;
    assign rs2_val = (wb_we_i && wb_sel_i != 5'd0 && wb_sel_i == de_data_i.rs2_sel) ?
                     wb_data_i : de_data_i.rs2_data;

    assign op_a = ctrl.src_a_pc  ? de_data_i.pc  : rs1_val;
    assign op_b = ctrl.src_b_imm ? de_data_i.imm : rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // branch compare always on the register values
    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:  taken = (rs1_val == rs2_val);
            BR_BNE:  taken = (rs1_val != rs2_val);
            BR_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_BLTU: taken = (rs1_val < rs2_val);
            BR_BGEU: taken = (rs1_val >= rs2_val);
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = de_valid_i & taken;
    assign redirect_pc_o = (ctrl.br_kind == BR_JALR) ?
                           ((rs1_val + de_data_i.imm) & 32'hffff_fffe) :
                           (de_data_i.pc + de_data_i.imm);

    assign exe_valid_o  = de_valid_i;
    assign exe_rd_we_o  = ctrl.rd_we;
    assign exe_rd_sel_o = ctrl.rd_sel;
    assign exe_result_o = ctrl.link ? (de_data_i.pc + 32'd4) : alu_out;  // link wins

endmodule

`default_nettype wire

// File: result_unit.sv
`timescale 1ns/100ps
`default_nettype none

module result_unit (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        exe_valid_i,
    input  wire logic        exe_rd_we_i,
    input  wire logic [4:0]  exe_rd_sel_i,
    input  wire logic [31:0] exe_result_i,
    output logic             wb_we_o,
    output logic [4:0]       wb_sel_o,
    output logic [31:0]      wb_data_o,
    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output logic [31:0]      commit_data_o
);

    logic        valid_q;
    logic        we_q;
    logic [4:0]  sel_q;
    logic [31:0] data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= exe_valid_i;
            we_q    <= exe_valid_i & exe_rd_we_i & (exe_rd_sel_i != 5'd0);  // x0 dropped here
        end
    end

    always_ff @(posedge clk_i) begin
        sel_q  <= exe_rd_sel_i;
        data_q <= exe_result_i;
    end

    assign wb_we_o   = we_q;
    assign wb_sel_o  = sel_q;
    assign wb_data_o = data_q;

    // every valid instruction commits, non-writers as rd 0 / data 0
    assign commit_valid_o = valid_q;
    assign commit_rd_o    = we_q ? sel_q  : 5'd0;
    assign commit_data_o  = we_q ? data_q : 32'd0;

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    output logic             imem_req_o,
    output logic [31:0]      imem_addr_o,
    input  wire logic        imem_resp_i,
    input  wire logic [31:0] imem_rdata_i,
    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output logic [31:0]      commit_data_o
);

    logic        redirect;
    logic [31:0] redirect_pc;

    logic        fd_load;
    logic        fd_valid_in;
    fd_payload_t fd_data_in;
    logic        fd_valid;
    fd_payload_t fd_data;

    logic        de_valid_in;
    de_payload_t de_data_in;
    logic        de_valid;
    de_payload_t de_data;

    logic        exe_valid;
    logic        exe_rd_we;
    logic [4:0]  exe_rd_sel;
    logic [31:0] exe_result;

    logic        wb_we;
    logic [4:0]  wb_sel;
    logic [31:0] wb_data;

    fetch_unit fetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .imem_resp_i   (imem_resp_i),
        .imem_rdata_i  (imem_rdata_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .fd_load_o     (fd_load),
        .fd_valid_o    (fd_valid_in),
        .fd_data_o     (fd_data_in)
    );

    stage_reg #(.payload_t(fd_payload_t)) fd_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (fd_load),
        .flush_i (redirect),
        .valid_i (fd_valid_in),
        .data_i  (fd_data_in),
        .valid_o (fd_valid),
        .data_o  (fd_data)
    );

    decode_unit decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fd_valid_i (fd_valid),
        .fd_data_i  (fd_data),
        .wb_we_i    (wb_we),
        .wb_sel_i   (wb_sel),
        .wb_data_i  (wb_data),
        .de_valid_o (de_valid_in),
        .de_data_o  (de_data_in)
    );

    // de boundary never stalls
    stage_reg #(.payload_t(de_payload_t)) de_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (1'b1),
        .flush_i (redirect),
        .valid_i (de_valid_in),
        .data_i  (de_data_in),
        .valid_o (de_valid),
        .data_o  (de_data)
    );

    execute_unit execute (
        .de_valid_i    (de_valid),
        .de_data_i     (de_data),
        .wb_we_i       (wb_we),
        .wb_sel_i      (wb_sel),
        .wb_data_i     (wb_data),
        .exe_valid_o   (exe_valid),
        .exe_rd_we_o   (exe_rd_we),
        .exe_rd_sel_o  (exe_rd_sel),
        .exe_result_o  (exe_result),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    result_unit result (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .exe_valid_i    (exe_valid),
        .exe_rd_we_i    (exe_rd_we),
        .exe_rd_sel_i   (exe_rd_sel),
        .exe_result_i   (exe_result),
        .wb_we_o        (wb_we),
        .wb_sel_o       (wb_sel),
        .wb_data_o      (wb_data),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_consts.svh"

module tb_rv_core;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_resp = 1'b0;
    logic [31:0] imem_rdata = 32'd0;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    // program image and expected commit records
    logic [31:0] imem [logic [31:0]];
    logic [31:0] last_addr = 32'd0;
    int          num_words = 0;
    logic [2:0]  exp_test [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    // instruction port model
    logic [31:0] rng_state = 32'h17a5;
    logic        busy = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;

    // fetch port history, one cycle back
    int          run_cycles = 0;
    logic        prev_req = 1'b0;
    logic        prev_resp = 1'b0;
    logic [31:0] prev_addr = 32'd0;

    string       test_name [0:7];
    int          test_errs [0:7];
    int          total_errs = 0;
    int          extra_commits = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    logic [2:0]  cur_test;
    logic [4:0]  rd_now;
    logic [31:0] data_now;

    rv_core dut_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .imem_req_o     (imem_req),
        .imem_addr_o    (imem_addr),
        .imem_resp_i    (imem_resp),
        .imem_rdata_i   (imem_rdata),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] w;
        if (imem.exists(addr)) begin
            w = imem[addr];
        end else begin
            w = `RV_NOP;  // hole in the program
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected, input logic [2:0] test);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            test_errs[test] = test_errs[test] + 1;
            total_errs = total_errs + 1;
        end
    endtask

    task automatic report_test(input logic [2:0] test);
        if (test_errs[test] == 0) begin
            $display("test %0d %s: ok", test, test_name[test]);
            tests_pass = tests_pass + 1;
        end else begin
            $display("test %0d %s: failed, %0d errors", test, test_name[test],
                     test_errs[test]);
            tests_fail = tests_fail + 1;
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("rv_core_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 2 && line.getc(0) != "#") begin
                    rest = line.substr(2, line.len() - 1);
                    if (line.getc(0) == "M") begin
                        n = $sscanf(rest, "%h %h", a, b);
                        imem[a] = b;
                        num_words = num_words + 1;
                        if (a > last_addr) begin
                            last_addr = a;
                        end
                    end else if (line.getc(0) == "C") begin
                        n = $sscanf(rest, "%h %h %h", a, b, c);
                        exp_test.push_back(a[2:0]);
                        exp_rd.push_back(b[4:0]);
                        exp_data.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // answers 1 to 4 cycles after it sees a request and ignores fetches past the program
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_resp <= 1'b0;
            busy      <= 1'b0;
        end else if (imem_resp) begin
            imem_resp <= 1'b0;  // single-cycle strobe
            busy      <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 2'd0) begin
                imem_resp  <= 1'b1;
                imem_rdata <= fetch_word(imem_addr);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else if (imem_req && imem_addr <= last_addr) begin
            rng_state = next_random(rng_state);
            busy     <= 1'b1;
            wait_cnt <= rng_state[1:0];
        end
    end

    // fetch port rules and commit records
    always @(negedge clk) begin
        if (!rst_n) begin
            run_cycles = 0;
            check_value("imem_req_o", {31'd0, imem_req}, 32'd0, 3'd6);
            check_value("commit_valid_o", {31'd0, commit_valid}, 32'd0, 3'd6);
        end else begin
            run_cycles = run_cycles + 1;
            if (run_cycles <= 2) begin
                // request rises one cycle after the core sees the release
                check_value("imem_req_o", {31'd0, imem_req}, {31'd0, run_cycles == 2},
                            3'd6);
            end else if (!prev_resp) begin
                // held until answered and never low two cycles running
                check_value("imem_req_o", {31'd0, imem_req}, 32'd1, 3'd6);
                if (prev_req) begin
                    check_value("imem_addr_o", imem_addr, prev_addr, 3'd6);
                end
            end
        end
        prev_req  = imem_req;
        prev_resp = imem_resp;
        prev_addr = imem_addr;

        if (rst_n && commit_valid) begin
            if (exp_rd.size() == 0) begin
                $display("unexpected commit after the last expected one, rd %0d data %h",
                         commit_rd, commit_data);
                extra_commits = extra_commits + 1;
            end else begin
                cur_test = exp_test.pop_front();
                rd_now   = exp_rd.pop_front();
                data_now = exp_data.pop_front();
                check_value("commit_rd_o", {27'd0, commit_rd}, {27'd0, rd_now}, cur_test);
                check_value("commit_data_o", commit_data, data_now, cur_test);
                if (exp_test.size() == 0 || exp_test[0] != cur_test) begin
                    report_test(cur_test);
                end
            end
        end
    end

    initial begin
        wait (num_words > 0);
        repeat (40 * num_words * 4) @(posedge clk);
        $display("timeout: commits still missing after %0d cycles", 40 * num_words * 4);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        test_name[1] = "alu ops";
        test_name[2] = "forwarding";
        test_name[3] = "branches";
        test_name[4] = "jal and jalr";
        test_name[5] = "upper immediates and x0";
        test_name[6] = "full commit stream and fetch port";
        load_stim();
        if (num_words == 0 || exp_rd.size() == 0) begin
            $display("could not read a program and commits from rv_core_stim.txt");
            $display(">>> FAIL");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            rst_n <= 1'b1;
            while (exp_rd.size() != 0) begin
                @(posedge clk);
            end
            repeat (20) @(posedge clk);  // core waits past the program end with no commits
            test_errs[6] = total_errs + extra_commits;
            report_test(3'd6);
            $display("tests passed %0d failed %0d", tests_pass, tests_fail);
            if (tests_fail == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rv_core_stim.txt
# M <byte address> <instruction word>, unlisted addresses read as nop
# C <test> <rd> <data>, in commit order
M 00000000 00500093
M 00000004 ffd00113
M 00000008 002081b3
M 0000000c 40208233
M 00000010 00309293
M 00000014 40115313
M 00000018 01c15393
M 0000001c 00112433
M 00000020 001134b3
M 00000024 0f014513
M 00000028 0050e5b3
M 0000002c 07f17613
M 00000030 001096b3
M 00000034 00700713
M 00000038 00e707b3
M 0000003c 40e78833
M 00000040 00f848b3
M 00000044 00188893
M 00000048 00208463
M 0000004c 00108463
M 00000054 00109463
M 00000058 00209663
M 0000005c 00100913
M 00000060 00200913
M 00000064 0020c463
M 00000068 00114463
M 00000070 00115463
M 00000074 0020d463
M 0000007c 00116463
M 00000080 0020e463
M 00000088 0020f463
M 0000008c 00117463
M 00000094 00400913
M 00000098 00c009ef
M 0000009c 00100a13
M 000000a0 00200a13
M 000000a4 01198ae7
M 000000ac 004a8a13
M 000000b0 12345b37
M 000000b4 00001b97
M 000000b8 fffffc37
M 000000bc 00908013
M 000000c0 00100cb3
M 000000c4 00000000
M 000000c8 345b0d13
C 1 01 00000005
C 1 02 fffffffd
C 1 03 00000002
C 1 04 00000008
C 1 05 00000028
C 1 06 fffffffe
C 1 07 0000000f
C 1 08 00000001
C 1 09 00000000
C 1 0a ffffff0d
C 1 0b 0000002d
C 1 0c 0000007d
C 1 0d 000000a0
C 2 0e 00000007
C 2 0f 0000000e
C 2 10 00000007
C 2 11 00000009
C 2 11 0000000a
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 00 00000000
C 3 12 00000004
C 4 13 0000009c
C 4 15 000000a8
C 4 14 000000ac
C 5 16 12345000
C 5 17 000010b4
C 5 18 fffff000
C 5 00 00000000
C 5 19 00000005
C 5 00 00000000
C 5 1a 12345345

// File: rv_core.f
+incdir+.
rv_core_pkg.sv
stage_reg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
rv_core.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator, output kept in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
